// File: design/ntt_shuffle_pkg.sv
// shared types for the NTT read-side shuffle stage
package ntt_shuffle_pkg;

    // coefficient width, every packed width below is derived from it
    localparam int COEFF_W = 24;

    // coefficient memory depth in words
    localparam int MEM_WORDS = 64;

    // reset value of the sequencer LFSR, must be nonzero
    localparam logic [15:0] LFSR_SEED = 16'hace1;

    typedef logic [COEFF_W-1:0] coeff_t;

    // four coefficients per memory word, lane 0 sits in the low bits
    typedef coeff_t [3:0] quad_t;

    typedef logic [5:0] mem_addr_t;

    // row or column index inside one 4x4 block
    typedef logic [1:0] ptr_t;

    typedef logic [3:0] block_t;

    // one request towards the coefficient memory
    typedef struct packed {
        logic      req;
        logic      we;
        mem_addr_t addr;
        quad_t     wdata;
    } mem_req_t;

    // one drained column, rows 0 to 3 in lanes 0 to 3
    typedef struct packed {
        logic   valid;
        ptr_t   col;
        block_t block;
        quad_t  data;
    } out_word_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        LAST,
        DRAIN_ONLY
    } seq_state_t;

endpackage

// File: design/ntt_shuffle_buffer.sv
`timescale 1ns/1ps

module ntt_shuffle_buffer (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  logic                  wren,
    input  logic                  rden,
    input  logic                  wr_rst_count,
    input  ntt_shuffle_pkg::ptr_t wrptr,
    input  ntt_shuffle_pkg::ptr_t rdptr,
    input  ntt_shuffle_pkg::quad_t data_i,
    output logic                  buf_valid,
    output ntt_shuffle_pkg::quad_t data_o
);

    // store[half][row] is one memory word, so store[half][row][col] is a coefficient
    ntt_shuffle_pkg::quad_t [1:0][3:0] store;

    // number of words written into the current half, and its copy one cycle late
    ntt_shuffle_pkg::ptr_t wr_cnt;
    ntt_shuffle_pkg::ptr_t wr_cnt_d;

    // half_q marks the half being filled, the other one is drained
    logic half_q;
    logic wr_half;
    logic rd_half;

    // the counter wraps from 3 to 0 on the fourth write, the late copy still shows 3
    assign buf_valid = (wr_cnt_d == 2'd3) && (wr_cnt == 2'd0);

    // a write landing in the buf_valid cycle already belongs to the next block
    assign wr_half = half_q ^ buf_valid;

    // the drain half follows the registered pointer so that the last column of
    // a block is still read from the right half while the next one completes
    assign rd_half = ~half_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            store <= '0;
        end else if (zeroize) begin
            store <= '0;
        end else if (wren) begin
            store[wr_half][wrptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt   <= '0;
            wr_cnt_d <= '0;
        end else if (zeroize || wr_rst_count) begin
            wr_cnt   <= '0;
            wr_cnt_d <= '0;
        end else begin
            if (wren) begin
                wr_cnt <= wr_cnt + 2'd1;
            end
            wr_cnt_d <= wr_cnt;
        end
    end

    // swap halves once per completed block
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            half_q <= 1'b0;
        end else if (zeroize) begin
            half_q <= 1'b0;
        end else if (buf_valid) begin
            half_q <= ~half_q;
        end
    end

    // gather column rdptr across the four rows of the full half
    always_comb begin
        data_o = '0;
        if (rden) begin
            for (int r = 0; r < 4; r++) begin
                data_o[r] = store[rd_half][r][rdptr];
            end
        end
    end

endmodule

// File: design/coeff_mem.sv
`timescale 1ns/1ps

module coeff_mem (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       en,
    input  logic                       we,
    input  ntt_shuffle_pkg::mem_addr_t addr,
    input  ntt_shuffle_pkg::quad_t     wdata,
    output ntt_shuffle_pkg::quad_t     rdata
);

    ntt_shuffle_pkg::quad_t mem [ntt_shuffle_pkg::MEM_WORDS];

    // writes are blocked while zeroize is asserted
    // the array itself keeps its contents
    always_ff @(posedge clk) begin
        if (en && we && !zeroize) begin
            mem[addr] <= wdata;
        end
    end

    // registered read port, one cycle from en to rdata
    // the register holds its value on writes and idle cycles
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdata <= '0;
        end else if (zeroize) begin
            rdata <= '0;
        end else if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                       clk,
    input  logic                       reset_n,
    input  ntt_shuffle_pkg::mem_req_t  host_in,
    input  ntt_shuffle_pkg::mem_req_t  seq_in,
    input  ntt_shuffle_pkg::quad_t     mem_rdata,
    output logic                       host_gnt,
    output logic                       seq_gnt,
    output logic                       seq_rvalid,
    output logic                       host_rvalid,
    output logic                       mem_en,
    output logic                       mem_we,
    output ntt_shuffle_pkg::mem_addr_t mem_addr,
    output ntt_shuffle_pkg::quad_t     mem_wdata,
    output ntt_shuffle_pkg::quad_t     rdata_out
);

    ntt_shuffle_pkg::mem_req_t winner;

    // which side issued the read that returns in this cycle
    logic host_rd_q;
    logic seq_rd_q;

    // the host always wins, the sequencer only gets the idle cycles
    assign host_gnt = host_in.req;
    assign seq_gnt  = seq_in.req && !host_in.req;

    assign winner = host_in.req ? host_in : seq_in;

    assign mem_en    = winner.req;
    assign mem_we    = winner.we;
    assign mem_addr  = winner.addr;
    assign mem_wdata = winner.wdata;

    // remember granted reads for one cycle to match the memory latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            host_rd_q <= 1'b0;
            seq_rd_q  <= 1'b0;
        end else begin
            host_rd_q <= host_gnt && !host_in.we;
            seq_rd_q  <= seq_gnt && !seq_in.we;
        end
    end

    assign host_rvalid = host_rd_q;
    assign seq_rvalid  = seq_rd_q;

    // read data only leaves the arbiter in a cycle that one side is waiting for
    assign rdata_out = (host_rd_q || seq_rd_q) ? mem_rdata : '0;

endmodule

// File: design/ntt_read_seq.sv
`timescale 1ns/1ps

module ntt_read_seq #(
    parameter int NUM_BLOCKS = 16
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      start,
    input  logic                      seq_gnt,
    input  logic                      seq_rvalid,
    input  logic                      buf_valid,
    output ntt_shuffle_pkg::mem_req_t seq_out,
    output logic                      wren,
    output logic                      wr_rst_count,
    output logic                      rden,
    output logic                      done,
    output logic                      busy,
    output ntt_shuffle_pkg::ptr_t     wrptr,
    output ntt_shuffle_pkg::ptr_t     rdptr,
    output ntt_shuffle_pkg::ptr_t     out_col,
    output ntt_shuffle_pkg::block_t   out_block,
    output logic                      out_valid
);

    localparam ntt_shuffle_pkg::mem_addr_t LAST_ADDR =
        ntt_shuffle_pkg::mem_addr_t'(NUM_BLOCKS*4 - 1);
    localparam ntt_shuffle_pkg::block_t LAST_BLOCK =
        ntt_shuffle_pkg::block_t'(NUM_BLOCKS - 1);

    ntt_shuffle_pkg::seq_state_t state;
    ntt_shuffle_pkg::mem_addr_t  addr_q;
    ntt_shuffle_pkg::ptr_t       wr_row;
    ntt_shuffle_pkg::ptr_t       start_col;
    ntt_shuffle_pkg::ptr_t       drain_k;
    ntt_shuffle_pkg::block_t     fill_blk;
    ntt_shuffle_pkg::block_t     drain_blk;
    logic                        drain_active;
    logic                        last_col;
    logic [15:0]                 lfsr;

    // the last column of the last block ends the run
    assign last_col = drain_active && (drain_k == 2'd3) && (drain_blk == LAST_BLOCK)
                      && (state == ntt_shuffle_pkg::DRAIN_ONLY);

    // the sequencer only reads, and its address is block times four plus row
    assign seq_out.req   = (state == ntt_shuffle_pkg::FETCH);
    assign seq_out.we    = 1'b0;
    assign seq_out.addr  = addr_q;
    assign seq_out.wdata = '0;

    assign wren         = seq_rvalid;
    assign wrptr        = wr_row;
    assign wr_rst_count = start && (state == ntt_shuffle_pkg::IDLE);
    assign busy         = (state != ntt_shuffle_pkg::IDLE);

    // drain order is the random start column, then onwards modulo four
    assign rden      = drain_active;
    assign rdptr     = ntt_shuffle_pkg::ptr_t'(start_col + drain_k);
    assign out_col   = rdptr;
    assign out_block = drain_blk;
    assign out_valid = drain_active;

    // requests go out in FETCH and LAST waits for the final block to fill
    // DRAIN_ONLY then empties that block while nothing else is in flight
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= ntt_shuffle_pkg::IDLE;
            addr_q <= '0;
            wr_row <= '0;
            done   <= 1'b0;
        end else if (zeroize) begin
            state  <= ntt_shuffle_pkg::IDLE;
            addr_q <= '0;
            wr_row <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            // returned words fill rows 0 to 3 of the current block
            if (seq_rvalid) begin
                wr_row <= wr_row + 2'd1;
            end
            case (state)
                ntt_shuffle_pkg::IDLE: begin
                    if (start) begin
                        state  <= ntt_shuffle_pkg::FETCH;
                        addr_q <= '0;
                        wr_row <= '0;
                    end
                end
                ntt_shuffle_pkg::FETCH: begin
                    // host traffic holds the address until the next grant
                    if (seq_gnt) begin
                        addr_q <= addr_q + 6'd1;
                        if (addr_q == LAST_ADDR) begin
                            state <= ntt_shuffle_pkg::LAST;
                        end
                    end
                end
                ntt_shuffle_pkg::LAST: begin
                    // every earlier block has completed before the final grant
                    if (buf_valid) begin
                        state <= ntt_shuffle_pkg::DRAIN_ONLY;
                    end
                end
                ntt_shuffle_pkg::DRAIN_ONLY: begin
                    if (last_col) begin
                        state <= ntt_shuffle_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ntt_shuffle_pkg::IDLE;
            endcase
        end
    end

    // a new full half restarts the column count and picks a fresh start column
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            drain_active <= 1'b0;
            drain_k      <= '0;
            start_col    <= '0;
            fill_blk     <= '0;
            drain_blk    <= '0;
        end else if (zeroize || wr_rst_count) begin
            drain_active <= 1'b0;
            drain_k      <= '0;
            start_col    <= '0;
            fill_blk     <= '0;
            drain_blk    <= '0;
        end else if (buf_valid) begin
            drain_active <= 1'b1;
            drain_k      <= '0;
            start_col    <= lfsr[1:0];
            drain_blk    <= fill_blk;
            fill_blk     <= fill_blk + 4'd1;
        end else if (drain_active) begin
            drain_k <= drain_k + 2'd1;
            if (drain_k == 2'd3) begin
                drain_active <= 1'b0;
            end
        end
    end

    // the x^16 + x^14 + x^13 + x^11 Fibonacci LFSR steps only during a run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= ntt_shuffle_pkg::LFSR_SEED;
        end else if (zeroize) begin
            lfsr <= ntt_shuffle_pkg::LFSR_SEED;
        end else if (busy) begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

endmodule

// File: design/ntt_shuffle_top.sv
`timescale 1ns/1ps

module ntt_shuffle_top #(
    parameter int NUM_BLOCKS = 16
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       start,
    input  ntt_shuffle_pkg::mem_req_t  host_in,
    output logic                       host_gnt,
    output logic                       host_rvalid,
    output ntt_shuffle_pkg::quad_t     host_rdata,
    output ntt_shuffle_pkg::out_word_t out,
    output logic                       busy,
    output logic                       done
);

    // memory side
    logic                       mem_en;
    logic                       mem_we;
    ntt_shuffle_pkg::mem_addr_t mem_addr;
    ntt_shuffle_pkg::quad_t     mem_wdata;
    ntt_shuffle_pkg::quad_t     mem_rdata;
    ntt_shuffle_pkg::quad_t     rdata;

    // sequencer to arbiter and buffer
    ntt_shuffle_pkg::mem_req_t  seq_req;
    logic                       seq_gnt;
    logic                       seq_rvalid;
    logic                       wren;
    logic                       rden;
    logic                       wr_rst_count;
    logic                       buf_valid;
    ntt_shuffle_pkg::ptr_t      wrptr;
    ntt_shuffle_pkg::ptr_t      rdptr;
    ntt_shuffle_pkg::ptr_t      out_col;
    ntt_shuffle_pkg::block_t    out_block;
    logic                       out_valid;
    ntt_shuffle_pkg::quad_t     buf_data;

    coeff_mem u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .en      (mem_en),
        .we      (mem_we),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .reset_n     (reset_n),
        .host_in     (host_in),
        .seq_in      (seq_req),
        .mem_rdata   (mem_rdata),
        .host_gnt    (host_gnt),
        .seq_gnt     (seq_gnt),
        .seq_rvalid  (seq_rvalid),
        .host_rvalid (host_rvalid),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .rdata_out   (rdata)
    );

    ntt_read_seq #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_seq (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .start        (start),
        .seq_gnt      (seq_gnt),
        .seq_rvalid   (seq_rvalid),
        .buf_valid    (buf_valid),
        .seq_out      (seq_req),
        .wren         (wren),
        .wr_rst_count (wr_rst_count),
        .rden         (rden),
        .done         (done),
        .busy         (busy),
        .wrptr        (wrptr),
        .rdptr        (rdptr),
        .out_col      (out_col),
        .out_block    (out_block),
        .out_valid    (out_valid)
    );

    ntt_shuffle_buffer u_buf (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .wren         (wren),
        .rden         (rden),
        .wr_rst_count (wr_rst_count),
        .wrptr        (wrptr),
        .rdptr        (rdptr),
        .data_i       (rdata),
        .buf_valid    (buf_valid),
        .data_o       (buf_data)
    );

    // host reads share the steered read bus with the buffer
    assign host_rdata = rdata;

    // the sequencer labels each drained column, the buffer supplies its data
    assign out.valid = out_valid;
    assign out.col   = out_col;
    assign out.block = out_block;
    assign out.data  = buf_data;

endmodule

// File: tests/ntt_shuffle_props.sv
`timescale 1ns/1ps

module ntt_shuffle_props (
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input logic host_gnt,
    input logic seq_gnt,
    input logic buf_valid,
    input logic out_valid,
    input logic done
);

    // number of failed assertions, the testbench watches it
    int fail_count = 0;

    // the memory has one port, so at most one side may own it
    gnt_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(host_gnt && seq_gnt))
        else begin
            $error("host and sequencer granted in the same cycle");
            fail_count++;
        end

    // a full half drains in four cycles, a back-to-back block may extend the burst
    drain_four: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        buf_valid |=> out_valid [*4] ##1 (!out_valid || $past(buf_valid)))
        else begin
            $error("drain burst after buf_valid was not four cycles long");
            fail_count++;
        end

    // done comes right after the last drained column
    done_after_word: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> $past(out_valid))
        else begin
            $error("done without an output word in the previous cycle");
            fail_count++;
        end

endmodule

bind ntt_shuffle_top ntt_shuffle_props u_props (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .host_gnt  (host_gnt),
    .seq_gnt   (seq_gnt),
    .buf_valid (buf_valid),
    .out_valid (out.valid),
    .done      (done)
);

// File: tests/ntt_shuffle_tb.sv
`timescale 1ns/1ps

module ntt_shuffle_tb;

    localparam int NUM_BLOCKS = 16;
    localparam int NUM_TESTS = 4;
    // the whole simulation gets forty cycles per block and test plus some margin
    localparam int WATCHDOG_CYCLES = NUM_TESTS * NUM_BLOCKS * 40 + 200;
    // one start-to-done run may take forty cycles per block with host traffic
    localparam int RUN_LIMIT = NUM_BLOCKS * 40;

    logic                       clk;
    logic                       reset_n;
    logic                       zeroize;
    logic                       start;
    ntt_shuffle_pkg::mem_req_t  host_in;
    logic                       host_gnt;
    logic                       host_rvalid;
    ntt_shuffle_pkg::quad_t     host_rdata;
    ntt_shuffle_pkg::out_word_t out_w;
    logic                       busy;
    logic                       done;

    // every host write also lands in this image of the coefficient memory
    ntt_shuffle_pkg::quad_t mem_img [64];

    // words collected by the output monitor during one run
    ntt_shuffle_pkg::out_word_t words [$];
    int                         done_count;
    int                         words_at_done;
    integer                     seed;

    ntt_shuffle_top #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .host_in     (host_in),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .out         (out_w),
        .busy        (busy),
        .done        (done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch %s: actual 0x%h expected 0x%h",
                               name, actual, expected));
        end
    endtask

    function automatic ntt_shuffle_pkg::quad_t rand_quad();
        ntt_shuffle_pkg::quad_t q;
        for (int l = 0; l < 4; l++) begin
            q[l] = ntt_shuffle_pkg::coeff_t'($random(seed));
        end
        return q;
    endfunction

    // lane r of column c in block b is coefficient c of word b*4+r
    function automatic ntt_shuffle_pkg::quad_t expected_column(input int b, input int c);
        ntt_shuffle_pkg::quad_t e;
        for (int r = 0; r < 4; r++) begin
            e[r] = mem_img[b*4 + r][c];
        end
        return e;
    endfunction

    // the host holds its request for one cycle and read data comes back a cycle later
    task automatic host_access(input logic we, input ntt_shuffle_pkg::mem_addr_t addr,
                               input ntt_shuffle_pkg::quad_t wdata);
        @(negedge clk);
        host_in.req   = 1'b1;
        host_in.we    = we;
        host_in.addr  = addr;
        host_in.wdata = wdata;
        if (we) begin
            mem_img[addr] = wdata;
        end
        #1;
        check("host_gnt", host_gnt, 1'b1);
        @(negedge clk);
        host_in = '0;
        check("host_rvalid", host_rvalid, !we);
        if (!we) begin
            check("host_rdata", host_rdata, mem_img[addr]);
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < 64; a++) begin
            host_access(1'b1, ntt_shuffle_pkg::mem_addr_t'(a), rand_quad());
        end
    endtask

    task automatic clear_monitor();
        words.delete();
        done_count    = 0;
        words_at_done = 0;
    endtask

    task automatic start_run();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check("busy after start", busy, 1'b1);
    endtask

    // random host reads may stall the sequencer while the run waits for done
    task automatic wait_done(input bit traffic);
        int                         cycles;
        bit                         seen;
        bit                         pending;
        ntt_shuffle_pkg::mem_addr_t paddr;
        cycles  = 0;
        seen    = 0;
        pending = 0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (pending) begin
                check("host_rvalid during run", host_rvalid, 1'b1);
                check("host_rdata during run", host_rdata, mem_img[paddr]);
                pending = 0;
            end
            host_in = '0;
            if (done) begin
                seen = 1;
            end else if (cycles > RUN_LIMIT) begin
                fail_run("the sequencer never raised done within the run limit");
            end else if (traffic && (($random(seed) & 3) == 0)) begin
                paddr        = ntt_shuffle_pkg::mem_addr_t'($random(seed));
                host_in.req  = 1'b1;
                host_in.addr = paddr;
                pending      = 1;
                #1;
                check("host_gnt during run", host_gnt, 1'b1);
            end
        end
    endtask

    // compare everything the monitor saw against the memory image
    task automatic check_stream();
        int                         b;
        logic [3:0]                 starts;
        ntt_shuffle_pkg::out_word_t w;
        ntt_shuffle_pkg::ptr_t      col_exp;
        check("out word count", words.size(), NUM_BLOCKS * 4);
        check("done pulse count", done_count, 1);
        check("out words before done", words_at_done, NUM_BLOCKS * 4);
        check("busy after done", busy, 1'b0);
        starts = '0;
        for (int i = 0; i < words.size(); i++) begin
            w = words[i];
            b = i / 4;
            check("out.block", w.block, b);
            // columns run on from the block's first column and wrap modulo four
            col_exp = ntt_shuffle_pkg::ptr_t'(words[b*4].col + (i % 4));
            check("out.col", w.col, col_exp);
            check("out.data", w.data, expected_column(b, w.col));
            if (i % 4 == 0) begin
                starts[w.col] = 1'b1;
            end
        end
        if (NUM_BLOCKS > 1) begin
            check("more than one start column", $countones(starts) > 1, 1'b1);
        end
    endtask

    task automatic run_stream(input bit traffic);
        clear_monitor();
        start_run();
        wait_done(traffic);
        // a few idle cycles so that stray words or a second done would show up
        repeat (8) @(negedge clk);
        check("out.valid after done", out_w.valid, 1'b0);
        check_stream();
    endtask

    task automatic load_and_read_back();
        load_memory();
        for (int a = 0; a < 64; a++) begin
            host_access(1'b0, ntt_shuffle_pkg::mem_addr_t'(a), '0);
        end
    endtask

    task automatic drain_transposed();
        run_stream(1'b0);
    endtask

    task automatic drain_under_host_reads();
        run_stream(1'b1);
    endtask

    task automatic zeroize_then_reset();
        int cycles;
        clear_monitor();
        start_run();
        cycles = 0;
        while (words.size() < 6) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                fail_run("no output words appeared before zeroize");
            end
        end
        zeroize = 1'b1;
        @(negedge clk);
        check("busy under zeroize", busy, 1'b0);
        check("out.valid under zeroize", out_w.valid, 1'b0);
        check("done under zeroize", done, 1'b0);
        zeroize = 1'b0;
        reset_n = 1'b0;
        repeat (3) @(negedge clk);
        check("busy in reset", busy, 1'b0);
        check("out.valid in reset", out_w.valid, 1'b0);
        check("done in reset", done, 1'b0);
        reset_n = 1'b1;
        @(negedge clk);
        check("busy after reset", busy, 1'b0);
        check("out.valid after reset", out_w.valid, 1'b0);
        check("done after reset", done, 1'b0);
        // new data keeps stale buffer contents from matching the image
        load_memory();
        run_stream(1'b0);
    endtask

    // the monitor samples on the falling edge where all DUT outputs have settled
    always @(negedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            fail_run("a bound assertion on the DUT failed");
        end
        if (reset_n) begin
            if (out_w.valid) begin
                words.push_back(out_w);
            end
            if (done) begin
                done_count++;
                words_at_done = words.size();
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout: the tests did not finish within %0d cycles",
                           WATCHDOG_CYCLES));
    end

    initial begin
        seed    = 32'h3d25_a4c8;
        reset_n = 1'b0;
        zeroize = 1'b0;
        start   = 1'b0;
        host_in = '0;
        clear_monitor();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check("out.valid after power-up", out_w.valid, 1'b0);
        check("done after power-up", done, 1'b0);
        check("busy after power-up", busy, 1'b0);
        load_and_read_back();
        drain_transposed();
        drain_under_host_reads();
        zeroize_then_reset();
        repeat (4) @(negedge clk);
        if (uut.u_props.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

endmodule

// File: compile.f
design/ntt_shuffle_pkg.sv
design/ntt_shuffle_buffer.sv
design/coeff_mem.sv
design/mem_arbiter.sv
design/ntt_read_seq.sv
design/ntt_shuffle_top.sv
tests/ntt_shuffle_props.sv
tests/ntt_shuffle_tb.sv

// File: Bender.yml
package:
  name: ntt_shuffle

sources:
  - files:
      - design/ntt_shuffle_pkg.sv
      - design/ntt_shuffle_buffer.sv
      - design/coeff_mem.sv
      - design/mem_arbiter.sv
      - design/ntt_read_seq.sv
      - design/ntt_shuffle_top.sv

  - target: test
    files:
      - tests/ntt_shuffle_props.sv
      - tests/ntt_shuffle_tb.sv
